//--- verilog/rotator_pkg.sv
//---------------------------------------------------------------------------
// Weight rotator shared definitions
// Sizes, configuration and output user structs, FSM state encodings
//---------------------------------------------------------------------------
package rotator_pkg;

  localparam int WORD_WIDTH   = 8;
  localparam int COLS         = 8;
  localparam int ROW_WIDTH    = WORD_WIDTH * COLS;
  localparam int S_WIDTH      = 32;
  localparam int S_KEEP_WIDTH = S_WIDTH / WORD_WIDTH;

  localparam int KW_MAX     = 7;   // Odd kernel widths only
  localparam int CIN_MAX    = 16;
  localparam int BANK_DEPTH = 128;
  localparam int ADDR_BITS  = $clog2(BANK_DEPTH);

  // Counter and field widths
  localparam int KW_BITS  = $clog2(KW_MAX);
  localparam int KW2_BITS = $clog2((KW_MAX + 1) / 2);
  localparam int CIN_BITS = $clog2(CIN_MAX);
  localparam int COL_BITS = 4;
  localparam int BLK_BITS = 3;
  localparam int XN_BITS  = 3;

  // Sits in the low bits of the configuration beat
  typedef struct packed {
    logic [XN_BITS-1:0]  xn_1;
    logic [BLK_BITS-1:0] blocks_1;
    logic [COL_BITS-1:0] cols_1;
    logic [CIN_BITS-1:0] cin_1;
    logic [KW2_BITS-1:0] kw2;      // kw = 2*kw2 + 1
  } config_st;

  localparam int CFG_WIDTH = $bits(config_st);

  typedef struct packed {
    logic                is_config;
    logic [KW2_BITS-1:0] kw2;
    logic                is_w_first_clk;  // First tap, channel 0, column 0
    logic                is_cin_last;
    logic                is_w_last;
    logic                is_col_1_k2;
  } tuser_st;

  typedef enum logic [1:0] {
    W_IDLE,
    W_GET_REF,
    W_WRITE,
    W_SWITCH
  } write_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_PASS_CONFIG,
    R_READ,
    R_SWITCH
  } read_state_e;

endpackage

//--- verilog/weight_width_adapter.sv
//---------------------------------------------------------------------------
// Weight width adapter
// Packs two 32-bit beats into one 64-bit row, zeroing bytes without keep.
// A last beat closes the row early.
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_width_adapter (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                i_s_valid,
  input  logic [rotator_pkg::S_WIDTH-1:0]      i_s_data,
  input  logic [rotator_pkg::S_KEEP_WIDTH-1:0] i_s_keep,
  input  logic                                i_s_last,
  output logic                                o_s_ready,
  output logic                                o_m_valid,
  output logic [rotator_pkg::ROW_WIDTH-1:0]    o_m_data,
  output logic                                o_m_last
);
  import rotator_pkg::*;

  logic               half_q;   // Low half of the row is filled
  logic [S_WIDTH-1:0] masked;
  logic               s_hs;

  assign o_s_ready = !o_m_valid;
  assign s_hs      = i_s_valid && o_s_ready;

  always_comb begin
    for (int b = 0; b < S_KEEP_WIDTH; b++) begin
      masked[b*WORD_WIDTH +: WORD_WIDTH] = i_s_keep[b] ? i_s_data[b*WORD_WIDTH +: WORD_WIDTH]
                                                       : '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      half_q    <= 1'b0;
      o_m_valid <= 1'b0;
    end else begin
      o_m_valid <= 1'b0;     // Row is a single-cycle pulse
      if (s_hs) begin
        if (half_q || i_s_last) begin
          o_m_valid <= 1'b1;
          half_q    <= 1'b0;
        end else begin
          half_q    <= 1'b1;
        end
      end
    end
  end

  // Row payload
  always_ff @(posedge aclk) begin
    if (s_hs) begin
      o_m_last <= i_s_last;
      if (!half_q) begin
        o_m_data[S_WIDTH-1:0] <= masked;
        if (i_s_last) o_m_data[ROW_WIDTH-1:S_WIDTH] <= '0;  // Short row
      end else begin
        o_m_data[ROW_WIDTH-1:S_WIDTH] <= masked;
      end
    end
  end

endmodule

//--- verilog/weight_bank_ram.sv
//---------------------------------------------------------------------------
// Weight bank
// Sequential write with recorded end address, wrapping read pointer,
// one cycle read latency
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_bank_ram (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             i_clear,
  input  logic                             i_wen,
  input  logic [rotator_pkg::ROW_WIDTH-1:0] i_wdata,
  input  logic                             i_wlast,
  input  logic                             i_ren,
  input  logic                             i_rrestart,
  output logic [rotator_pkg::ROW_WIDTH-1:0] o_rdata
);
  import rotator_pkg::*;

  logic [ROW_WIDTH-1:0] mem [BANK_DEPTH];
  logic [ADDR_BITS-1:0] wptr;
  logic [ADDR_BITS-1:0] end_addr;
  logic [ADDR_BITS-1:0] rptr;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wptr     <= '0;
      end_addr <= '0;
      rptr     <= '0;
    end else begin
      if (i_clear) begin
        wptr <= '0;
      end else if (i_wen) begin
        wptr <= wptr + 1'b1;
        if (i_wlast) end_addr <= wptr;
      end

      if (i_rrestart) begin
        rptr <= '0;
      end else if (i_ren) begin
        rptr <= (rptr == end_addr) ? '0 : rptr + 1'b1;  // Kernel replays from 0
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wen) mem[wptr] <= i_wdata;
    if (i_ren) o_rdata <= mem[rptr];
  end

endmodule

//--- verilog/weight_ref_regs.sv
//---------------------------------------------------------------------------
// Reference registers
// Per-bank configuration and the done flags handing banks between
// the write and read FSMs
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_ref_regs (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_cap_en,
  input  logic                  i_cap_bank,
  input  rotator_pkg::config_st i_cap_cfg,
  input  logic                  i_wr_start,
  input  logic                  i_wr_done,
  input  logic                  i_wr_bank,
  input  logic                  i_rd_start,
  input  logic                  i_rd_done,
  input  logic                  i_rd_bank,
  output rotator_pkg::config_st o_cfg_0,
  output rotator_pkg::config_st o_cfg_1,
  output logic [1:0]            o_done_write,
  output logic [1:0]            o_done_read
);
  import rotator_pkg::*;

  always_ff @(posedge aclk) begin
    if (i_cap_en && !i_cap_bank) o_cfg_0 <= i_cap_cfg;
    if (i_cap_en &&  i_cap_bank) o_cfg_1 <= i_cap_cfg;
  end

  // Both banks start free for the writer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_done_write <= 2'b00;
      o_done_read  <= 2'b11;
    end else begin
      if (i_wr_start) o_done_write[i_wr_bank] <= 1'b0;
      if (i_wr_done)  o_done_write[i_wr_bank] <= 1'b1;
      if (i_rd_start) o_done_read[i_rd_bank]  <= 1'b0;
      if (i_rd_done) begin
        o_done_read[i_rd_bank]  <= 1'b1;
        o_done_write[i_rd_bank] <= 1'b0;   // Consumed, must be refilled
      end
    end
  end

endmodule

//--- verilog/weight_write_ctrl.sv
//---------------------------------------------------------------------------
// Write controller
// Takes the configuration beat, then steers weight rows from the
// width adapter into the current write bank
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_write_ctrl (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                i_s_tvalid,
  input  logic [rotator_pkg::S_WIDTH-1:0]      i_s_tdata,
  input  logic [rotator_pkg::S_KEEP_WIDTH-1:0] i_s_tkeep,
  input  logic                                i_s_tlast,
  output logic                                o_s_tready,
  output logic                                o_ad_valid,
  output logic [rotator_pkg::S_WIDTH-1:0]      o_ad_data,
  output logic [rotator_pkg::S_KEEP_WIDTH-1:0] o_ad_keep,
  output logic                                o_ad_last,
  input  logic                                i_ad_ready,
  input  logic                                i_row_valid,
  input  logic [rotator_pkg::ROW_WIDTH-1:0]    i_row_data,
  input  logic                                i_row_last,
  output logic                                o_cap_en,
  output rotator_pkg::config_st               o_cap_cfg,
  output logic [1:0]                          o_wen,
  output logic [1:0]                          o_wlast,
  output logic [1:0]                          o_clear,
  output logic [rotator_pkg::ROW_WIDTH-1:0]    o_wdata,
  output logic                                o_wr_bank,
  output logic                                o_wr_start,
  output logic                                o_wr_done,
  input  logic [1:0]                          i_done_read
);
  import rotator_pkg::*;

  write_state_e state;
  logic         pass_q;   // Weight beats of the packet go to the adapter
  logic         s_hs;

  assign s_hs       = i_s_tvalid && o_s_tready;
  assign o_s_tready = (state == W_GET_REF) || (pass_q && i_ad_ready);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= W_IDLE;
      pass_q    <= 1'b0;
      o_wr_bank <= 1'b0;
    end else begin
      case (state)
        W_IDLE:    if (i_done_read[o_wr_bank]) state <= W_GET_REF;
        W_GET_REF: if (s_hs) state <= W_WRITE;
        W_WRITE:   if (i_row_valid && i_row_last) state <= W_SWITCH;
        W_SWITCH: begin
          state     <= W_IDLE;
          o_wr_bank <= !o_wr_bank;
        end
        default:   state <= W_IDLE;
      endcase

      if (state == W_GET_REF && s_hs) pass_q <= 1'b1;
      else if (pass_q && s_hs && i_s_tlast) pass_q <= 1'b0;
    end
  end

  // Input toward the adapter
  assign o_ad_valid = i_s_tvalid && pass_q;
  assign o_ad_data  = i_s_tdata;
  assign o_ad_keep  = i_s_tkeep;
  assign o_ad_last  = i_s_tlast;

  assign o_cap_en   = (state == W_GET_REF) && s_hs;
  assign o_cap_cfg  = i_s_tdata[CFG_WIDTH-1:0];
  assign o_wr_start = (state == W_GET_REF);
  assign o_wr_done  = (state == W_SWITCH);
  assign o_wdata    = i_row_data;

  always_comb begin
    o_wen              = 2'b00;
    o_wlast            = 2'b00;
    o_clear            = 2'b00;
    o_clear[o_wr_bank] = (state == W_GET_REF);   // Rewind write pointer
    o_wen[o_wr_bank]   = (state == W_WRITE) && i_row_valid;
    o_wlast[o_wr_bank] = (state == W_WRITE) && i_row_valid && i_row_last;
  end

endmodule

//--- verilog/weight_read_ctrl.sv
//---------------------------------------------------------------------------
// Read controller
// Emits the configuration beat, then replays the stored kernel per column,
// block and pass. Rows land in a two-entry output buffer.
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_read_ctrl (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  rotator_pkg::config_st            i_cfg_0,
  input  rotator_pkg::config_st            i_cfg_1,
  input  logic [1:0]                       i_done_write,
  input  logic [rotator_pkg::ROW_WIDTH-1:0] i_rdata_0,
  input  logic [rotator_pkg::ROW_WIDTH-1:0] i_rdata_1,
  output logic [1:0]                       o_ren,
  output logic [1:0]                       o_rrestart,
  output logic                             o_rd_bank,
  output logic                             o_rd_start,
  output logic                             o_rd_done,
  output logic                             o_m_tvalid,
  input  logic                             i_m_tready,
  output logic [rotator_pkg::ROW_WIDTH-1:0] o_m_tdata,
  output logic                             o_m_tlast,
  output rotator_pkg::tuser_st             o_m_tuser
);
  import rotator_pkg::*;

  typedef struct packed {
    logic [ROW_WIDTH-1:0] data;
    tuser_st              user;
    logic                 last;
  } beat_st;

  read_state_e         state;
  config_st            cfg;
  logic [KW_BITS-1:0]  c_kw;
  logic [CIN_BITS-1:0] c_cin;
  logic [COL_BITS-1:0] c_col;
  logic [BLK_BITS-1:0] c_blk;
  logic [XN_BITS-1:0]  c_xn;
  logic                l_kw, l_cin, l_col, l_blk, l_xn, last_all;
  logic                pop, room, issue, read_en;
  logic [2:0]          occ;
  tuser_st             user_next;
  logic                pipe_v, pipe_cfg, pipe_last;
  tuser_st             pipe_user;
  beat_st              beat_in, head;
  beat_st              buf_q [2];
  logic [1:0]          count;
  logic                wr_ptr, rd_ptr;

  assign cfg = o_rd_bank ? i_cfg_1 : i_cfg_0;

  // Only issue when the row can still land in the buffer
  assign pop     = o_m_tvalid && i_m_tready;
  assign occ     = 3'(count) + 3'(pipe_v);
  assign room    = (occ - 3'(pop)) < 3'd2;
  assign issue   = room && (state == R_PASS_CONFIG || state == R_READ);
  assign read_en = issue && (state == R_READ);

  assign l_kw     = (c_kw == {cfg.kw2, 1'b0});
  assign l_cin    = (c_cin == cfg.cin_1);
  assign l_col    = (c_col == cfg.cols_1);
  assign l_blk    = (c_blk == cfg.blocks_1);
  assign l_xn     = (c_xn == cfg.xn_1);
  assign last_all = l_kw && l_cin && l_col && l_blk && l_xn;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= R_IDLE;
      o_rd_bank <= 1'b0;
    end else begin
      case (state)
        R_IDLE:        if (i_done_write[o_rd_bank]) state <= R_PASS_CONFIG;
        R_PASS_CONFIG: if (issue) state <= R_READ;
        R_READ:        if (read_en && last_all) state <= R_SWITCH;
        R_SWITCH: begin
          state     <= R_IDLE;
          o_rd_bank <= !o_rd_bank;
        end
        default:       state <= R_IDLE;
      endcase
    end
  end

  // Nested counters, kernel tap innermost
  always_ff @(posedge aclk) begin
    if (!aresetn || state == R_IDLE) begin
      c_kw  <= '0;
      c_cin <= '0;
      c_col <= '0;
      c_blk <= '0;
      c_xn  <= '0;
    end else if (read_en) begin
      c_kw <= l_kw ? '0 : c_kw + 1'b1;
      if (l_kw) begin
        c_cin <= l_cin ? '0 : c_cin + 1'b1;
        if (l_cin) begin
          c_col <= l_col ? '0 : c_col + 1'b1;
          if (l_col) begin
            c_blk <= l_blk ? '0 : c_blk + 1'b1;
            if (l_blk) c_xn <= l_xn ? '0 : c_xn + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    user_next     = '0;
    user_next.kw2 = cfg.kw2;
    if (state == R_PASS_CONFIG) begin
      user_next.is_config = 1'b1;   // Position flags stay low here
    end else begin
      user_next.is_w_first_clk = (c_col == '0) && (c_cin == '0) && (c_kw == '0);
      user_next.is_cin_last    = l_kw && l_cin;
      user_next.is_w_last      = l_col;
      user_next.is_col_1_k2    = (c_col == COL_BITS'(cfg.kw2));
    end
  end

  always_comb begin
    o_ren                 = 2'b00;
    o_rrestart            = 2'b00;
    o_ren[o_rd_bank]      = read_en;
    o_rrestart[o_rd_bank] = (state == R_IDLE);
  end

  assign o_rd_start = (state == R_IDLE) && i_done_write[o_rd_bank];
  assign o_rd_done  = (state == R_SWITCH);

  // Tags follow the bank read latency
  always_ff @(posedge aclk) begin
    if (!aresetn) pipe_v <= 1'b0;
    else          pipe_v <= issue;
  end

  always_ff @(posedge aclk) begin
    if (issue) begin
      pipe_cfg  <= (state == R_PASS_CONFIG);
      pipe_user <= user_next;
      pipe_last <= read_en && last_all;
    end
  end

  always_comb begin
    beat_in.data = pipe_cfg  ? {{(ROW_WIDTH-CFG_WIDTH){1'b0}}, cfg} :
                   o_rd_bank ? i_rdata_1 : i_rdata_0;
    beat_in.user = pipe_user;
    beat_in.last = pipe_last;
  end

  // Output buffer
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count  <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      count <= count + 2'(pipe_v) - 2'(pop);
      if (pipe_v) wr_ptr <= !wr_ptr;
      if (pop)    rd_ptr <= !rd_ptr;
    end
  end

  always_ff @(posedge aclk) begin
    if (pipe_v) buf_q[wr_ptr] <= beat_in;
  end

  assign head       = buf_q[rd_ptr];
  assign o_m_tvalid = (count != '0);
  assign o_m_tdata  = head.data;
  assign o_m_tuser  = head.user;
  assign o_m_tlast  = o_m_tvalid && head.last;

endmodule

//--- verilog/axis_weight_rotator.sv
//---------------------------------------------------------------------------
// AXI-Stream weight rotator
// Double-banked kernel store: one bank fills while the other replays
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module axis_weight_rotator (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                i_s_tvalid,
  output logic                                o_s_tready,
  input  logic [rotator_pkg::S_WIDTH-1:0]      i_s_tdata,
  input  logic [rotator_pkg::S_KEEP_WIDTH-1:0] i_s_tkeep,
  input  logic                                i_s_tlast,
  output logic                                o_m_tvalid,
  input  logic                                i_m_tready,
  output logic [rotator_pkg::ROW_WIDTH-1:0]    o_m_tdata,
  output logic                                o_m_tlast,
  output rotator_pkg::tuser_st                o_m_tuser
);
  import rotator_pkg::*;

  logic                    ad_valid, ad_last, ad_ready;
  logic [S_WIDTH-1:0]      ad_data;
  logic [S_KEEP_WIDTH-1:0] ad_keep;
  logic                    row_valid, row_last;
  logic [ROW_WIDTH-1:0]    row_data, wdata, rdata_0, rdata_1;
  logic                    cap_en, wr_bank, wr_start, wr_done;
  logic                    rd_bank, rd_start, rd_done;
  config_st                cap_cfg, cfg_0, cfg_1;
  logic [1:0]              wen, wlast, clear, ren, rrestart, done_write, done_read;

  weight_width_adapter adapter (
    .aclk, .aresetn,
    .i_s_valid (ad_valid), .i_s_data (ad_data), .i_s_keep (ad_keep),
    .i_s_last  (ad_last),  .o_s_ready (ad_ready),
    .o_m_valid (row_valid), .o_m_data (row_data), .o_m_last (row_last)
  );

  weight_write_ctrl write_ctrl (
    .aclk, .aresetn,
    .i_s_tvalid, .i_s_tdata, .i_s_tkeep, .i_s_tlast, .o_s_tready,
    .o_ad_valid (ad_valid), .o_ad_data (ad_data), .o_ad_keep (ad_keep),
    .o_ad_last  (ad_last),  .i_ad_ready (ad_ready),
    .i_row_valid (row_valid), .i_row_data (row_data), .i_row_last (row_last),
    .o_cap_en (cap_en), .o_cap_cfg (cap_cfg),
    .o_wen (wen), .o_wlast (wlast), .o_clear (clear), .o_wdata (wdata),
    .o_wr_bank (wr_bank), .o_wr_start (wr_start), .o_wr_done (wr_done),
    .i_done_read (done_read)
  );

  weight_bank_ram bank0 (
    .aclk, .aresetn,
    .i_clear (clear[0]), .i_wen (wen[0]), .i_wdata (wdata), .i_wlast (wlast[0]),
    .i_ren (ren[0]), .i_rrestart (rrestart[0]), .o_rdata (rdata_0)
  );

  weight_bank_ram bank1 (
    .aclk, .aresetn,
    .i_clear (clear[1]), .i_wen (wen[1]), .i_wdata (wdata), .i_wlast (wlast[1]),
    .i_ren (ren[1]), .i_rrestart (rrestart[1]), .o_rdata (rdata_1)
  );

  weight_ref_regs ref_regs (
    .aclk, .aresetn,
    .i_cap_en (cap_en), .i_cap_bank (wr_bank), .i_cap_cfg (cap_cfg),
    .i_wr_start (wr_start), .i_wr_done (wr_done), .i_wr_bank (wr_bank),
    .i_rd_start (rd_start), .i_rd_done (rd_done), .i_rd_bank (rd_bank),
    .o_cfg_0 (cfg_0), .o_cfg_1 (cfg_1),
    .o_done_write (done_write), .o_done_read (done_read)
  );

  weight_read_ctrl read_ctrl (
    .aclk, .aresetn,
    .i_cfg_0 (cfg_0), .i_cfg_1 (cfg_1), .i_done_write (done_write),
    .i_rdata_0 (rdata_0), .i_rdata_1 (rdata_1),
    .o_ren (ren), .o_rrestart (rrestart),
    .o_rd_bank (rd_bank), .o_rd_start (rd_start), .o_rd_done (rd_done),
    .o_m_tvalid, .i_m_tready, .o_m_tdata, .o_m_tlast, .o_m_tuser
  );

endmodule

//--- tests/rotator_asserts.sv
//---------------------------------------------------------------------------
// Weight rotator output protocol checks
// Stability under stall, last only on the final kernel beat, quiet in reset
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module rotator_asserts (
  input logic                             aclk,
  input logic                             aresetn,
  input logic                             o_m_tvalid,
  input logic                             i_m_tready,
  input logic [rotator_pkg::ROW_WIDTH-1:0] o_m_tdata,
  input logic                             o_m_tlast,
  input rotator_pkg::tuser_st             o_m_tuser
);
  import rotator_pkg::*;

  int assert_fails = 0;

  // Held beat must not change until taken
  assert property (@(posedge aclk) disable iff (!aresetn)
    o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata) &&
                                  $stable(o_m_tlast) && $stable(o_m_tuser))
    else begin
      assert_fails++;
      $error("output beat changed while stalled");
    end

  // Last tap of the last channel in the last column
  assert property (@(posedge aclk) disable iff (!aresetn)
    o_m_tlast |-> o_m_tvalid && !o_m_tuser.is_config &&
                  o_m_tuser.is_cin_last && o_m_tuser.is_w_last)
    else begin
      assert_fails++;
      $error("tlast outside the final kernel beat");
    end

  assert property (@(posedge aclk) !aresetn |=> !o_m_tvalid)
    else begin
      assert_fails++;
      $error("tvalid high during reset");
    end

endmodule

bind axis_weight_rotator rotator_asserts protocol_chk (.*);

//--- tests/tb_axis_weight_rotator.sv
//---------------------------------------------------------------------------
// Weight rotator testbench
// Replays packets from the data file and checks every output beat
//---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_axis_weight_rotator;
  import rotator_pkg::*;

  localparam int DRV_TIMEOUT = 2000;
  localparam int MON_TIMEOUT = 1000;
  localparam int HOLD_CYCLES = 200;

  logic                    aclk = 1'b0;
  logic                    aresetn;
  logic                    i_s_tvalid, i_s_tlast, i_m_tready;
  logic [S_WIDTH-1:0]      i_s_tdata;
  logic [S_KEEP_WIDTH-1:0] i_s_tkeep;
  logic                    o_s_tready, o_m_tvalid, o_m_tlast;
  logic [ROW_WIDTH-1:0]    o_m_tdata;
  tuser_st                 o_m_tuser;

  logic [31:0]          td [0:63];
  int                   rec_base [0:15];
  int                   rec_mode [0:15];   // 0 high, 1 random, 2 stall hold
  int                   nrec;
  logic                 rand_ready = 1'b0;   // Record on the output wants random ready
  logic                 stall_out = 1'b0;    // Output held off while a config beat waits
  integer               seed = 32'hb9b0;
  int                   errors = 0;
  int                   checks = 0;
  logic [ROW_WIDTH-1:0] exp_data [$];
  tuser_st              exp_user [$];
  logic                 exp_last [$];
  int                   exp_rec [$];

  axis_weight_rotator uut (.*);

  always #2 aclk = !aclk;

  always @(posedge aclk) begin
    #1;
    if (stall_out)       i_m_tready = 1'b0;
    else if (rand_ready) i_m_tready = 1'($random(seed));
    else                 i_m_tready = 1'b1;
  end

  task automatic check_row(logic [ROW_WIDTH-1:0] got, logic [ROW_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_m_tdata got %h expected %h", got, exp);
    end
  endtask

  task automatic check_user(tuser_st got, tuser_st exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_m_tuser got %h expected %h", got, exp);
    end
  endtask

  task automatic check_last(logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED o_m_tlast got %h expected %h", got, exp);
    end
  endtask

  task automatic abort_run(string why);
    $display("Timeout: %s", why);
    $display("Something failed");
    $finish;
  endtask

  function automatic logic [S_WIDTH-1:0] mask_beat(logic [31:0] d, logic [31:0] k);
    logic [S_WIDTH-1:0] m;
    for (int b = 0; b < S_KEEP_WIDTH; b++) begin
      m[b*8 +: 8] = k[b] ? d[b*8 +: 8] : 8'h00;
    end
    return m;
  endfunction

  // Expected stream of one record: config beat, then the kernel replays
  task automatic build_expected(int r, int base);
    config_st             cfg;
    int                   nb, kw, cin, idx;
    logic [ROW_WIDTH-1:0] rows [$];
    logic [S_WIDTH-1:0]   hi;
    tuser_st              u;
    cfg = td[base+1][CFG_WIDTH-1:0];
    nb  = td[base+2];
    for (int i = 0; i < nb; i += 2) begin
      hi = (i + 1 < nb) ? mask_beat(td[base+5+2*i], td[base+6+2*i]) : '0;
      rows.push_back({hi, mask_beat(td[base+3+2*i], td[base+4+2*i])});
    end
    u = '0;
    u.is_config = 1'b1;
    u.kw2 = cfg.kw2;
    exp_data.push_back({{(ROW_WIDTH-CFG_WIDTH){1'b0}}, cfg});
    exp_user.push_back(u);
    exp_last.push_back(1'b0);
    exp_rec.push_back(r);
    kw  = 2 * cfg.kw2 + 1;
    cin = cfg.cin_1 + 1;
    idx = 0;
    for (int x = 0; x <= cfg.xn_1; x++)
      for (int b = 0; b <= cfg.blocks_1; b++)
        for (int c = 0; c <= cfg.cols_1; c++)
          for (int ch = 0; ch < cin; ch++)
            for (int k = 0; k < kw; k++) begin
              u = '0;
              u.kw2            = cfg.kw2;
              u.is_w_first_clk = (c == 0) && (ch == 0) && (k == 0);
              u.is_cin_last    = (k == kw - 1) && (ch == cin - 1);
              u.is_w_last      = (c == cfg.cols_1);
              u.is_col_1_k2    = (c == cfg.kw2);
              exp_data.push_back(rows[idx]);
              exp_user.push_back(u);
              exp_last.push_back((x == cfg.xn_1) && (b == cfg.blocks_1) &&
                                 (c == cfg.cols_1) && u.is_cin_last);
              exp_rec.push_back(r);
              idx = (idx + 1) % rows.size();   // Bank wraps at its end address
            end
  endtask

  task automatic send_beat(logic [31:0] d, logic [31:0] k, logic last);
    int waited;
    waited     = 0;
    i_s_tvalid = 1'b1;
    i_s_tdata  = d;
    i_s_tkeep  = k[S_KEEP_WIDTH-1:0];
    i_s_tlast  = last;
    @(posedge aclk);
    while (!o_s_tready) begin
      waited++;
      if (waited > DRV_TIMEOUT) abort_run("input beat never accepted");
      @(posedge aclk);
    end
    #1 i_s_tvalid = 1'b0;
  endtask

  // Config beat offered while the output is stalled must wait
  task automatic hold_config(logic [31:0] d);
    int   cyc;
    logic taken;
    cyc        = 0;
    taken      = 1'b0;
    stall_out  = 1'b1;
    i_s_tvalid = 1'b1;
    i_s_tdata  = d;
    i_s_tkeep  = '1;
    i_s_tlast  = 1'b0;
    while (cyc < HOLD_CYCLES && !taken) begin
      @(posedge aclk);
      taken = o_s_tready;
      cyc++;
    end
    checks++;
    if (taken) begin
      errors++;
      $display("Configuration beat was accepted while both banks were busy");
      #1 i_s_tvalid = 1'b0;
      stall_out = 1'b0;
    end else begin
      #1 stall_out = 1'b0;
      send_beat(d, 32'hf, 1'b0);
    end
  endtask

  task automatic drive_record(int base);
    int mode, nb;
    mode = td[base];
    nb   = td[base+2];
    if (mode == 2) hold_config(td[base+1]);
    else           send_beat(td[base+1], 32'hf, 1'b0);
    for (int i = 0; i < nb; i++) begin
      send_beat(td[base+3+2*i], td[base+4+2*i], i == nb - 1);
    end
  endtask

  task automatic run_monitor;
    int waited, beats, errs_before, r;
    beats       = 0;
    errs_before = 0;
    while (exp_data.size() != 0) begin
      rand_ready = (rec_mode[exp_rec[0]] == 1);   // Ready pattern follows the output record
      waited = 0;
      @(posedge aclk);
      while (!(o_m_tvalid && i_m_tready)) begin
        waited++;
        if (waited > MON_TIMEOUT) abort_run("output beat did not arrive");
        @(posedge aclk);
      end
      check_row(o_m_tdata, exp_data.pop_front());
      check_user(o_m_tuser, exp_user.pop_front());
      r = exp_rec.pop_front();
      beats++;
      if (exp_last.pop_front()) begin
        check_last(o_m_tlast, 1'b1);
        $display("test %0d: %0d beats, %s", r, beats,
                 (errors == errs_before) ? "matched" : "mismatches");
        beats       = 0;
        errs_before = errors;
      end else begin
        check_last(o_m_tlast, 1'b0);
      end
    end
  endtask

  initial begin
    aresetn    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tkeep  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b1;
    $readmemh("tests/rotator_testdata.txt", td);
    nrec = td[0];
    rec_base[0] = 1;
    for (int r = 0; r < nrec; r++) begin
      if (r > 0) rec_base[r] = rec_base[r-1] + 3 + 2 * td[rec_base[r-1] + 2];
      rec_mode[r] = td[rec_base[r]];
      build_expected(r, rec_base[r]);
    end
    repeat (3) @(posedge aclk);
    #1 aresetn = 1'b1;
    fork
      begin
        for (int r = 0; r < nrec; r++) drive_record(rec_base[r]);
      end
      run_monitor();
    join
    errors += uut.protocol_chk.assert_fails;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- axis_weight_rotator.f
verilog/rotator_pkg.sv
verilog/weight_width_adapter.sv
verilog/weight_bank_ram.sv
verilog/weight_ref_regs.sv
verilog/weight_write_ctrl.sv
verilog/weight_read_ctrl.sv
verilog/axis_weight_rotator.sv
tests/rotator_asserts.sv
tests/tb_axis_weight_rotator.sv

//--- tests/rotator_testdata.txt
// Header line per record: mode (0 ready high, 1 random ready, 2 stall hold) config nbeats
// Then one line per weight beat: data keep. The first word is the record count.
5
0 000000c1 6
03020100 f
07060504 f
13121110 f
17161514 f
23222120 f
27262524 f
1 00002484 3
a3a2a1a0 f
a7a6a5a4 f
b3b2b1b0 3
0 00003fc4 4
c3c2c1c0 f
c7c6c5c4 f
d3d2d1d0 f
d7d6d5d4 f
0 00000001 5
e3e2e1e0 f
e7e6e5e4 f
f3f2f1f0 f
f7f6f5f4 f
5a5b5c5d 1
2 00000040 2
87654321 f
fedcba98 f
